/* Bender.yml */
package:
  name: vmfpu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mfpu_pkg.sv
      - vmfpu/mfpu_sequencer.sv
      - vmfpu/simd_mul.sv
      - vmfpu/mfpu_result_queue.sv
      - vmfpu/vmfpu.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/vmfpu_sva.sv
      - verification/tb_vmfpu.sv

/* common/mfpu_defs.svh */
// Global constants of the vector multiply unit
// Data width, queue depths, multiplier latency, instruction ids and widths

`ifndef MFPU_DEFS_SVH
`define MFPU_DEFS_SVH

// Width of one operand or result word
`define MFPU_ELEN 64

// Instructions held between accept and commit
`define MFPU_INSN_DEPTH 4

// Results buffered in front of the VRF port
`define MFPU_RESULT_DEPTH 2

// Registered stages of the SIMD multiplier
`define MFPU_MUL_LAT 2

// Number of instruction ids, one done bit each
`define MFPU_NR_VINSN 8

// VRF word address and vector length widths
`define MFPU_ADDR_W 10
`define MFPU_VL_W 10

`endif

/* common/mfpu_pkg.sv */
// Shared types of the vector multiply unit
// Opcode and element width enums, instruction, beat tag and pipeline structs

`default_nettype none

`include "mfpu_defs.svh"

package mfpu_pkg;

  typedef logic [`MFPU_ELEN-1:0]             elen_t;
  typedef logic [`MFPU_ELEN/8-1:0]           strb_t;
  typedef logic [$clog2(`MFPU_NR_VINSN)-1:0] vid_t;
  typedef logic [`MFPU_ADDR_W-1:0]           vaddr_t;
  typedef logic [`MFPU_VL_W-1:0]             vl_t;

  // A word holds 8 >> vew elements
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [1:0] {
    VMUL   = 2'd0,
    VMULH  = 2'd1,
    VMULHU = 2'd2,
    VMACC  = 2'd3
  } mul_op_e;

  typedef struct packed {
    vid_t    id;
    mul_op_e op;
    vew_e    vew;
    vl_t     vl;
    vaddr_t  vd;
    logic    use_scalar;
    elen_t   scalar;
  } vinsn_t;

  // Travels with every beat from issue to the VRF write
  typedef struct packed {
    vid_t       id;
    vew_e       vew;
    vaddr_t     addr;
    logic [3:0] cnt;
    logic       last;
  } beat_tag_t;

  typedef struct packed {
    elen_t     vs1;
    elen_t     vs2;
    elen_t     vd;
    mul_op_e   op;
    beat_tag_t tag;
  } mul_req_t;

  typedef struct packed {
    elen_t     wdata;
    beat_tag_t tag;
  } result_t;

endpackage

`default_nettype wire

/* flist.f */
+incdir+common
common/mfpu_pkg.sv
vmfpu/mfpu_sequencer.sv
vmfpu/simd_mul.sv
vmfpu/mfpu_result_queue.sv
vmfpu/vmfpu.sv
verification/vmfpu_sva.sv
verification/tb_vmfpu.sv

/* verification/tb_vmfpu.sv */
// Testbench of the vector multiply unit
// Clock and reset, LFSR stimulus, reference model, scoreboard assertions and summary

`timescale 1ns/1ps
`default_nettype none

`include "mfpu_defs.svh"

module tb_vmfpu;

  localparam int NrInsn  = 28;
  localparam int MaxBeat = 1024;
  localparam int Timeout = 20000;

  logic                      clk_i;
  logic                      rst_ni;
  mfpu_pkg::vinsn_t          vinsn;
  logic                      vinsn_valid;
  logic                      vinsn_ready;
  mfpu_pkg::elen_t [2:0]     operand;
  logic            [2:0]     operand_valid;
  logic            [2:0]     operand_ready;
  logic                      req;
  mfpu_pkg::vid_t            id;
  mfpu_pkg::vaddr_t          addr;
  mfpu_pkg::elen_t           wdata;
  mfpu_pkg::strb_t           be;
  logic                      gnt;
  logic [`MFPU_NR_VINSN-1:0] done;

  // Stimulus, operand queues and expected beats in issue order
  mfpu_pkg::vinsn_t insn_mem [NrInsn+1];
  mfpu_pkg::elen_t  op_mem [3][MaxBeat];
  int               op_wr [3];
  int               op_rd [3];
  logic [2:0]       use_mem [MaxBeat];
  mfpu_pkg::vid_t   exp_id_mem [MaxBeat];
  mfpu_pkg::vaddr_t exp_addr_mem [MaxBeat];
  mfpu_pkg::elen_t  exp_wdata_mem [MaxBeat];
  mfpu_pkg::strb_t  exp_be_mem [MaxBeat];
  logic             exp_last_mem [MaxBeat];
  int               insn_idx;
  int               exp_wr;
  int               exp_rd;
  int               done_cnt;
  int               cycle;
  int               err_cnt;
  logic [31:0]      lfsr;

  mfpu_pkg::vid_t            exp_id;
  mfpu_pkg::vaddr_t          exp_addr;
  mfpu_pkg::elen_t           exp_wdata;
  mfpu_pkg::strb_t           exp_be;
  logic [2:0]                exp_use;
  logic [`MFPU_NR_VINSN-1:0] exp_done;

  assign vinsn       = insn_mem[insn_idx];
  assign vinsn_valid = rst_ni && (insn_idx < NrInsn);
  for (genvar k = 0; k < 3; k++) begin : gen_opq
    assign operand[k]       = op_mem[k][op_rd[k]];
    assign operand_valid[k] = (op_rd[k] < op_wr[k]);
  end

  assign exp_id    = exp_id_mem[exp_rd];
  assign exp_addr  = exp_addr_mem[exp_rd];
  assign exp_wdata = exp_wdata_mem[exp_rd];
  assign exp_be    = exp_be_mem[exp_rd];
  // vs2 is taken on every beat, so its count is the beat number
  assign exp_use   = use_mem[op_rd[1]];
  assign exp_done  = (req && gnt && exp_last_mem[exp_rd]) ? `MFPU_NR_VINSN'(1) << exp_id : '0;

  vmfpu dut0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .vinsn_i        (vinsn),
    .vinsn_valid_i  (vinsn_valid),
    .vinsn_ready_o  (vinsn_ready),
    .operand_i      (operand),
    .operand_valid_i(operand_valid),
    .operand_ready_o(operand_ready),
    .result_req_o   (req),
    .result_id_o    (id),
    .result_addr_o  (addr),
    .result_wdata_o (wdata),
    .result_be_o    (be),
    .result_gnt_i   (gnt),
    .vinsn_done_o   (done)
  );

  bind vmfpu vmfpu_sva sva0 (.*);

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] next_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic mfpu_pkg::elen_t splat(input mfpu_pkg::elen_t s, input int w);
    mfpu_pkg::elen_t v;
    v = '0;
    for (int l = 0; l < 64 / w; l++) begin
      v = v | 64'((128'(s) & ((128'd1 << w) - 1)) << (l * w));
    end
    return v;
  endfunction

  // Lane-wise result of one op, computed on 128-bit values
  function automatic mfpu_pkg::elen_t word_model(input mfpu_pkg::mul_op_e op, input int w,
      input mfpu_pkg::elen_t a, input mfpu_pkg::elen_t b, input mfpu_pkg::elen_t c);
    logic [127:0]    mask;
    logic [127:0]    sbit;
    logic [127:0]    x;
    logic [127:0]    y;
    logic [127:0]    r;
    mfpu_pkg::elen_t v;
    mask = (128'd1 << w) - 1;
    sbit = 128'd1 << (w - 1);
    v    = '0;
    for (int l = 0; l < 64 / w; l++) begin
      x = (128'(a) >> (l * w)) & mask;
      y = (128'(b) >> (l * w)) & mask;
      if (op == mfpu_pkg::VMULHU) begin
        r = (x * y) >> w;
      end else begin
        // Sign extension by flipping and subtracting the sign bit
        r = ((x ^ sbit) - sbit) * ((y ^ sbit) - sbit);
        if (op == mfpu_pkg::VMULH) begin
          r = r >> w;
        end else if (op == mfpu_pkg::VMACC) begin
          r = r + (128'(c) >> (l * w));
        end
      end
      v = v | 64'((r & mask) << (l * w));
    end
    return v;
  endfunction

  task automatic build_model();
    mfpu_pkg::vinsn_t insn;
    mfpu_pkg::elen_t  vs1;
    mfpu_pkg::elen_t  vs2;
    mfpu_pkg::elen_t  vd;
    int               w;
    int               epw;
    int               left;
    int               cnt;
    for (int i = 0; i < NrInsn; i++) begin
      insn.id         = mfpu_pkg::vid_t'(i);
      // Every op at every width first, then scalar forms at random widths
      insn.op         = mfpu_pkg::mul_op_e'(i % 4);
      insn.vew        = (i < 16) ? mfpu_pkg::vew_e'(i / 4) : mfpu_pkg::vew_e'(2'(next_bits(2)));
      insn.vl         = mfpu_pkg::vl_t'(1 + next_bits(5));
      insn.vd         = mfpu_pkg::vaddr_t'(next_bits(10));
      insn.use_scalar = (i >= 16);
      insn.scalar     = next_bits(64);
      insn_mem[i]     = insn;
      w    = 8 << insn.vew;
      epw  = 64 / w;
      left = insn.vl;
      for (int b = 0; left > 0; b++) begin
        cnt = (left < epw) ? left : epw;
        vs1 = insn.use_scalar ? splat(insn.scalar, w) : next_bits(64);
        vs2 = next_bits(64);
        vd  = (insn.op == mfpu_pkg::VMACC) ? next_bits(64) : '0;
        use_mem[exp_wr] = {insn.op == mfpu_pkg::VMACC, 1'b1, !insn.use_scalar};
        for (int k = 0; k < 3; k++) begin
          if (use_mem[exp_wr][k]) begin
            op_mem[k][op_wr[k]] = (k == 0) ? vs1 : ((k == 1) ? vs2 : vd);
            op_wr[k]++;
          end
        end
        exp_id_mem[exp_wr]    = insn.id;
        exp_addr_mem[exp_wr]  = insn.vd + mfpu_pkg::vaddr_t'(b);
        exp_wdata_mem[exp_wr] = word_model(insn.op, w, vs1, vs2, vd);
        exp_be_mem[exp_wr]    = mfpu_pkg::strb_t'((16'd1 << (cnt * w / 8)) - 16'd1);
        exp_last_mem[exp_wr]  = (left <= epw);
        exp_wr++;
        left -= cnt;
      end
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Handshakes are taken at the edge, inputs change 1 ns later
  always @(posedge clk_i) begin : drive
    logic [2:0] took;
    logic       acc;
    logic       wrote;
    logic       fin;
    took  = operand_ready;
    acc   = vinsn_valid && vinsn_ready;
    wrote = req && gnt;
    fin   = (done != '0);
    #1;
    for (int k = 0; k < 3; k++) begin
      if (took[k]) begin
        op_rd[k]++;
      end
    end
    if (acc) begin
      insn_idx++;
    end
    if (wrote) begin
      exp_rd++;
    end
    if (fin) begin
      done_cnt++;
    end
    cycle++;
    // Long stretches without grant fill the result queue
    if (cycle % 250 >= 150) begin
      gnt = 1'b0;
    end else begin
      gnt = (next_bits(2) != 0);
    end
  end

  wdata_check: assert property (@(posedge clk_i) disable iff (!rst_ni) req && gnt |-> wdata == exp_wdata)
    else begin
      err_cnt++;
      $error("Mismatch result_wdata_o: got %h, expected %h", $sampled(wdata), $sampled(exp_wdata));
    end
  addr_check: assert property (@(posedge clk_i) disable iff (!rst_ni) req && gnt |-> addr == exp_addr)
    else begin
      err_cnt++;
      $error("Mismatch result_addr_o: got %h, expected %h", $sampled(addr), $sampled(exp_addr));
    end
  id_be_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
      req && gnt |-> id == exp_id && be == exp_be && exp_rd < exp_wr)
    else begin
      err_cnt++;
      $error("Mismatch result_id_o/result_be_o: got %h/%h, expected %h/%h",
             $sampled(id), $sampled(be), $sampled(exp_id), $sampled(exp_be));
    end
  done_check: assert property (@(posedge clk_i) disable iff (!rst_ni) done == exp_done)
    else begin
      err_cnt++;
      $error("Mismatch vinsn_done_o: got %h, expected %h", $sampled(done), $sampled(exp_done));
    end
  use_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
      operand_ready != '0 |-> operand_ready == exp_use)
    else begin
      err_cnt++;
      $error("Mismatch operand_ready_o: got %h, expected %h",
             $sampled(operand_ready), $sampled(exp_use));
    end

  initial begin : main
    int wait_cnt;
    rst_ni   = 1'b0;
    gnt      = 1'b0;
    lfsr     = 32'h7c865c99;
    insn_idx = 0;
    exp_wr   = 0;
    exp_rd   = 0;
    done_cnt = 0;
    cycle    = 0;
    err_cnt  = 0;
    for (int k = 0; k < 3; k++) begin
      op_wr[k] = 0;
      op_rd[k] = 0;
    end
    build_model();
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni   = 1'b1;
    wait_cnt = 0;
    while (done_cnt < NrInsn && wait_cnt < Timeout) begin
      @(posedge clk_i);
      wait_cnt++;
    end
    if (done_cnt < NrInsn) begin
      err_cnt++;
      $display("Timeout after %0d cycles with %0d of %0d instructions done",
               wait_cnt, done_cnt, NrInsn);
    end
    // Idle cycles in which no further write may appear
    repeat (20) @(posedge clk_i);
    if (exp_rd != exp_wr) begin
      err_cnt++;
      $display("Only %0d of %0d result beats were written", exp_rd, exp_wr);
    end
    $display("Errors: %0d scoreboard, %0d protocol", err_cnt, dut0.sva0.fail_cnt);
    if (err_cnt == 0 && dut0.sva0.fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/vmfpu_sva.sv */
// Protocol assertions of the vector multiply unit
// VRF request stability, instruction queue occupancy, done pulses, reset values

`timescale 1ns/1ps
`default_nettype none

`include "mfpu_defs.svh"

module vmfpu_sva (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      vinsn_valid_i,
  input  logic                      vinsn_ready_o,
  input  logic [2:0]                operand_ready_o,
  input  logic                      result_req_o,
  input  mfpu_pkg::vid_t            result_id_o,
  input  mfpu_pkg::vaddr_t          result_addr_o,
  input  mfpu_pkg::elen_t           result_wdata_o,
  input  mfpu_pkg::strb_t           result_be_o,
  input  logic                      result_gnt_i,
  input  logic [`MFPU_NR_VINSN-1:0] vinsn_done_o
);

  int unsigned fail_cnt = 0;

  // Instructions accepted and not yet done
  logic [2:0] held_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= '0;
    end else begin
      held_q <= held_q + 3'(vinsn_valid_i && vinsn_ready_o) - 3'(|vinsn_done_o);
    end
  end

  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o && !result_gnt_i |=> result_req_o && $stable(result_id_o)
      && $stable(result_addr_o) && $stable(result_wdata_o) && $stable(result_be_o))
    else begin
      fail_cnt++;
      $error("VRF request dropped or changed before it was granted");
    end

  queue_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
      vinsn_ready_o == (held_q != 3'd4))
    else begin
      fail_cnt++;
      $error("Instruction ready does not follow the number of held instructions");
    end

  done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
      vinsn_done_o != '0 |-> result_req_o && result_gnt_i && $onehot(vinsn_done_o))
    else begin
      fail_cnt++;
      $error("Done pulse is not one-hot or comes without a granted write");
    end

  reset_idle: assert property (@(posedge clk_i)
      !rst_ni |-> !result_req_o && operand_ready_o == '0 && vinsn_done_o == '0 && vinsn_ready_o)
    else begin
      fail_cnt++;
      $error("Outputs are not idle during reset");
    end

endmodule

`default_nettype wire

/* vmfpu/mfpu_result_queue.sv */
// Result queue in front of the VRF write port
// Byte enable formation, req/gnt write and per-instruction done pulse

`timescale 1ns/1ps
`default_nettype none

`include "mfpu_defs.svh"

module mfpu_result_queue (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  mfpu_pkg::result_t         res_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  output logic                      result_req_o,
  output mfpu_pkg::vid_t            result_id_o,
  output mfpu_pkg::vaddr_t          result_addr_o,
  output mfpu_pkg::elen_t           result_wdata_o,
  output mfpu_pkg::strb_t           result_be_o,
  input  logic                      result_gnt_i,
  output logic [`MFPU_NR_VINSN-1:0] vinsn_done_o,
  output logic                      commit_done_o
);

  localparam int unsigned Depth = `MFPU_RESULT_DEPTH;
  localparam int unsigned PntW  = (Depth > 1) ? $clog2(Depth) : 1;

  typedef struct packed {
    mfpu_pkg::vid_t   id;
    mfpu_pkg::vaddr_t addr;
    mfpu_pkg::elen_t  wdata;
    mfpu_pkg::strb_t  be;
    logic             last;
  } entry_t;

  entry_t          mem_q [Depth];
  logic [PntW-1:0] wr_pnt_q;
  logic [PntW-1:0] rd_pnt_q;
  logic [PntW:0]   cnt_q;

  entry_t          entry_d;
  entry_t          head;
  logic [3:0]      nbytes;
  logic            push;
  logic            pop;

  // Valid bytes are the low cnt elements of the word
  assign nbytes = 4'(res_i.tag.cnt << res_i.tag.vew);

  always_comb begin
    entry_d.id    = res_i.tag.id;
    entry_d.addr  = res_i.tag.addr;
    entry_d.wdata = res_i.wdata;
    entry_d.last  = res_i.tag.last;
    for (int b = 0; b < $bits(mfpu_pkg::strb_t); b++) begin
      entry_d.be[b] = (b < nbytes);
    end
  end

  assign head           = mem_q[rd_pnt_q];
  assign result_req_o   = (cnt_q != '0);
  assign result_id_o    = head.id;
  assign result_addr_o  = head.addr;
  assign result_wdata_o = head.wdata;
  assign result_be_o    = head.be;

  assign pop  = result_req_o && result_gnt_i;
  // A granted entry frees its slot in the same cycle
  assign ready_o = (cnt_q != (PntW+1)'(Depth)) || pop;
  assign push    = valid_i && ready_o;

  always_comb begin
    vinsn_done_o = '0;
    if (pop && head.last) begin
      vinsn_done_o[head.id] = 1'b1;
    end
  end

  assign commit_done_o = pop && head.last;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_pnt_q] <= entry_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_pnt_q <= (wr_pnt_q == PntW'(Depth-1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= (rd_pnt_q == PntW'(Depth-1)) ? '0 : rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + (PntW+1)'(push) - (PntW+1)'(pop);
    end
  end

endmodule

`default_nettype wire

/* vmfpu/mfpu_sequencer.sv */
// Instruction queue and beat issue of the multiply unit
// Operand handshake, scalar replication and per-beat tag generation

`timescale 1ns/1ps
`default_nettype none

`include "mfpu_defs.svh"

module mfpu_sequencer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mfpu_pkg::vinsn_t      vinsn_i,
  input  logic                  vinsn_valid_i,
  output logic                  vinsn_ready_o,
  input  mfpu_pkg::elen_t [2:0] operand_i,
  input  logic            [2:0] operand_valid_i,
  output logic            [2:0] operand_ready_o,
  output mfpu_pkg::mul_req_t    mul_req_o,
  output logic                  mul_valid_o,
  input  logic                  mul_ready_i,
  input  logic                  commit_done_i
);

  localparam int unsigned Depth = `MFPU_INSN_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);

  // Circular instruction queue
  mfpu_pkg::vinsn_t queue_q [Depth];
  logic [PntW-1:0]  accept_pnt_q;
  logic [PntW-1:0]  issue_pnt_q;
  // Instructions not yet fully issued, and not yet committed
  logic [PntW:0]    issue_cnt_q;
  logic [PntW:0]    commit_cnt_q;
  // Elements already issued of the current instruction
  mfpu_pkg::vl_t    elem_done_q;

  mfpu_pkg::vinsn_t cur;
  mfpu_pkg::vl_t    remaining;
  mfpu_pkg::elen_t  scalar_rep;
  logic [3:0]       epw;
  logic [2:0]       use_op;
  logic             accept;
  logic             issue_valid;
  logic             operands_ok;
  logic             fire;

  assign vinsn_ready_o = (commit_cnt_q != (PntW+1)'(Depth));
  assign accept        = vinsn_valid_i && vinsn_ready_o;

  assign cur         = queue_q[issue_pnt_q];
  assign issue_valid = (issue_cnt_q != '0);

  // Elements per word and what is left of the instruction
  assign epw       = 4'd8 >> cur.vew;
  assign remaining = cur.vl - elem_done_q;

  // vs1 is replaced by the scalar, vd is only read by VMACC
  assign use_op      = {cur.op == mfpu_pkg::VMACC, 1'b1, !cur.use_scalar};
  assign operands_ok = &(operand_valid_i | ~use_op);

  assign mul_valid_o     = issue_valid && operands_ok;
  assign fire            = mul_valid_o && mul_ready_i;
  assign operand_ready_o = fire ? use_op : 3'b000;

  always_comb begin
    unique case (cur.vew)
      mfpu_pkg::EW8:  scalar_rep = {8{cur.scalar[7:0]}};
      mfpu_pkg::EW16: scalar_rep = {4{cur.scalar[15:0]}};
      mfpu_pkg::EW32: scalar_rep = {2{cur.scalar[31:0]}};
      default:        scalar_rep = cur.scalar;
    endcase
  end

  always_comb begin
    mul_req_o.vs1      = cur.use_scalar ? scalar_rep : operand_i[0];
    mul_req_o.vs2      = operand_i[1];
    mul_req_o.vd       = operand_i[2];
    mul_req_o.op       = cur.op;
    mul_req_o.tag.id   = cur.id;
    mul_req_o.tag.vew  = cur.vew;
    // Every beat but the last is full, so the beat number follows from the count
    mul_req_o.tag.addr = cur.vd + mfpu_pkg::vaddr_t'(elem_done_q >> (2'd3 - cur.vew));
    mul_req_o.tag.last = (remaining <= mfpu_pkg::vl_t'(epw));
    mul_req_o.tag.cnt  = mul_req_o.tag.last ? remaining[3:0] : epw;
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      queue_q[accept_pnt_q] <= vinsn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      elem_done_q  <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (fire) begin
        if (mul_req_o.tag.last) begin
          issue_pnt_q <= issue_pnt_q + 1'b1;
          elem_done_q <= '0;
        end else begin
          elem_done_q <= elem_done_q + mfpu_pkg::vl_t'(epw);
        end
      end
      issue_cnt_q  <= issue_cnt_q + (PntW+1)'(accept)
                      - (PntW+1)'(fire && mul_req_o.tag.last);
      // Commits retire the oldest instruction
      commit_cnt_q <= commit_cnt_q + (PntW+1)'(accept) - (PntW+1)'(commit_done_i);
    end
  end

endmodule

`default_nettype wire

/* vmfpu/simd_mul.sv */
// Pipelined SIMD integer multiplier
// Lane products at 8, 16, 32 and 64 bits, high or low half and VMACC add
// A global stall holds every stage while the output is back-pressured

`timescale 1ns/1ps
`default_nettype none

`include "mfpu_defs.svh"

module simd_mul #(
  parameter int unsigned NumStages = `MFPU_MUL_LAT
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  mfpu_pkg::mul_req_t req_i,
  input  logic               valid_i,
  output logic               ready_o,
  output mfpu_pkg::result_t  res_o,
  output logic               valid_o,
  input  logic               ready_i
);

  // One candidate result word per element width
  mfpu_pkg::elen_t [3:0] res_ew;
  mfpu_pkg::result_t     res_d;

  mfpu_pkg::result_t     stage_q [NumStages];
  logic [NumStages-1:0]  stage_valid_q;
  logic                  stall;

  for (genvar g = 0; g < 4; g++) begin : gen_ew
    localparam int unsigned W  = 8 << g;
    localparam int unsigned NL = 8 >> g;

    for (genvar l = 0; l < NL; l++) begin : gen_lane
      logic        [W-1:0]   a;
      logic        [W-1:0]   b;
      logic        [W-1:0]   c;
      logic signed [2*W-1:0] prod_s;
      logic        [2*W-1:0] prod_u;
      logic        [W-1:0]   r;

      assign a = req_i.vs1[l*W +: W];
      assign b = req_i.vs2[l*W +: W];
      assign c = req_i.vd[l*W +: W];

      assign prod_s = $signed(a) * $signed(b);
      assign prod_u = a * b;

      // Low half is the same for signed and unsigned products
      always_comb begin
        unique case (req_i.op)
          mfpu_pkg::VMULH:  r = prod_s[2*W-1:W];
          mfpu_pkg::VMULHU: r = prod_u[2*W-1:W];
          mfpu_pkg::VMACC:  r = prod_s[W-1:0] + c;
          default:          r = prod_s[W-1:0];
        endcase
      end

      assign res_ew[g][l*W +: W] = r;
    end
  end

  assign res_d.wdata = res_ew[req_i.tag.vew];
  assign res_d.tag   = req_i.tag;

  assign stall   = stage_valid_q[NumStages-1] && !ready_i;
  assign ready_o = !stall;
  assign valid_o = stage_valid_q[NumStages-1];
  assign res_o   = stage_q[NumStages-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_valid_q <= '0;
    end else if (!stall) begin
      stage_valid_q[0] <= valid_i;
      for (int i = 1; i < NumStages; i++) begin
        stage_valid_q[i] <= stage_valid_q[i-1];
      end
    end
  end

  // Data and tag move with their valid bit
  always_ff @(posedge clk_i) begin
    if (!stall) begin
      stage_q[0] <= res_d;
      for (int i = 1; i < NumStages; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

endmodule

`default_nettype wire

/* vmfpu/vmfpu.sv */
// Vector integer multiply unit of one lane
// Sequencer, pipelined SIMD multiplier and result queue in a row

`timescale 1ns/1ps
`default_nettype none

`include "mfpu_defs.svh"

module vmfpu (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Instruction input
  input  mfpu_pkg::vinsn_t                vinsn_i,
  input  logic                            vinsn_valid_i,
  output logic                            vinsn_ready_o,
  // Operand queues, 0 = vs1, 1 = vs2, 2 = vd
  input  mfpu_pkg::elen_t [2:0]           operand_i,
  input  logic            [2:0]           operand_valid_i,
  output logic            [2:0]           operand_ready_o,
  // VRF write port
  output logic                            result_req_o,
  output mfpu_pkg::vid_t                  result_id_o,
  output mfpu_pkg::vaddr_t                result_addr_o,
  output mfpu_pkg::elen_t                 result_wdata_o,
  output mfpu_pkg::strb_t                 result_be_o,
  input  logic                            result_gnt_i,
  output logic [`MFPU_NR_VINSN-1:0]       vinsn_done_o
);

  mfpu_pkg::mul_req_t mul_req;
  logic               mul_valid;
  logic               mul_ready;
  mfpu_pkg::result_t  mul_res;
  logic               res_valid;
  logic               rq_ready;
  logic               commit_done;

  mfpu_sequencer i_sequencer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .vinsn_i        (vinsn_i),
    .vinsn_valid_i  (vinsn_valid_i),
    .vinsn_ready_o  (vinsn_ready_o),
    .operand_i      (operand_i),
    .operand_valid_i(operand_valid_i),
    .operand_ready_o(operand_ready_o),
    .mul_req_o      (mul_req),
    .mul_valid_o    (mul_valid),
    .mul_ready_i    (mul_ready),
    .commit_done_i  (commit_done)
  );

  simd_mul #(
    .NumStages(`MFPU_MUL_LAT)
  ) i_simd_mul (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (mul_req),
    .valid_i(mul_valid),
    .ready_o(mul_ready),
    .res_o  (mul_res),
    .valid_o(res_valid),
    .ready_i(rq_ready)
  );

  mfpu_result_queue i_result_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .res_i         (mul_res),
    .valid_i       (res_valid),
    .ready_o       (rq_ready),
    .result_req_o  (result_req_o),
    .result_id_o   (result_id_o),
    .result_addr_o (result_addr_o),
    .result_wdata_o(result_wdata_o),
    .result_be_o   (result_be_o),
    .result_gnt_i  (result_gnt_i),
    .vinsn_done_o  (vinsn_done_o),
    .commit_done_o (commit_done)
  );

endmodule

`default_nettype wire
